// File: list.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/refill_counter.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/tb_clkgen.sv
sim/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_dcache -f list.f -Mdir "$BUILD_DIR" -o tb_dcache; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_dcache" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
	echo "simulation exited with status $run_status"
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
fi

echo "pass line not found in $LOG"
exit 1

// File: sim/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 100
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// reset held low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge CLK);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache import dcache_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_STEPS  = 15;
	localparam int MEM_WORDS  = 1 << (`DC_ADDR_W - `DC_BYTE_W);

	// one processor transfer and the memory reads it should cost
	typedef struct packed {
		logic       we;
		addr_t      adr;
		word_t      dat;
		logic [2:0] reads;
	} step_t;

	logic    CLK;
	logic    rst_n;
	wb_req_t cpu_req;
	wb_rsp_t cpu_rsp;
	wb_req_t mem_req;
	wb_rsp_t mem_rsp;

	word_t mem [MEM_WORDS];
	word_t shadow [MEM_WORDS];
	step_t steps [NUM_STEPS];

	integer seed;
	int     mem_rd_cnt;
	int     mem_wr_cnt;
	addr_t  last_wr_adr;
	word_t  last_wr_dat;

	tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clkgen (
		.CLK   (CLK),
		.rst_n (rst_n)
	);

	dcache_top u_dut (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.mem_rsp (mem_rsp),
		.cpu_rsp (cpu_rsp),
		.mem_req (mem_req)
	);

	// start-up content where every word address gives its own value
	function automatic word_t fill_word(int unsigned widx);
		logic [9:0] a;
		a = widx[9:0];
		return {6'h2b, a, 6'h14, ~a};
	endfunction

	function automatic step_t make_step(logic we, addr_t adr, word_t dat, int reads);
		step_t s;
		s.we    = we;
		s.adr   = adr;
		s.dat   = dat;
		s.reads = reads[2:0];
		return s;
	endfunction

	task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// tags 2 and 7 fight over index 0
	task automatic load_table();
		steps[0]  = make_step(1'b0, 12'h104, 32'h0, 4);
		steps[1]  = make_step(1'b0, 12'h104, 32'h0, 0);
		steps[2]  = make_step(1'b0, 12'h10c, 32'h0, 0);
		steps[3]  = make_step(1'b1, 12'h108, 32'hdead_beef, 0);
		steps[4]  = make_step(1'b0, 12'h108, 32'h0, 0);
		steps[5]  = make_step(1'b1, 12'h234, 32'h1234_5678, 0);
		steps[6]  = make_step(1'b0, 12'h234, 32'h0, 4);
		steps[7]  = make_step(1'b0, 12'h384, 32'h0, 4);
		steps[8]  = make_step(1'b0, 12'h104, 32'h0, 4);
		steps[9]  = make_step(1'b0, 12'h388, 32'h0, 4);
		steps[10] = make_step(1'b0, 12'h108, 32'h0, 4);
		steps[11] = make_step(1'b0, 12'h7f0, 32'h0, 4);
		steps[12] = make_step(1'b1, 12'h7fc, 32'h0bad_f00d, 0);
		steps[13] = make_step(1'b0, 12'h7fc, 32'h0, 0);
		steps[14] = make_step(1'b0, 12'h384, 32'h0, 4);
	endtask

	// main memory that acks after 0 to 3 wait cycles
	initial begin : memory_model
		int   wait_cycles;
		logic busy;
		mem_rsp     = '0;
		mem_rd_cnt  = 0;
		mem_wr_cnt  = 0;
		last_wr_adr = '0;
		last_wr_dat = '0;
		busy        = 1'b0;
		wait_cycles = 0;
		seed        = 32'h0ffb_1d9c;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(i);
		end
		forever begin
			@(posedge CLK);
			#1;
			mem_rsp.ack = 1'b0;
			if (mem_req.cyc && mem_req.stb) begin
				if (!busy) begin
					busy        = 1'b1;
					wait_cycles = $random(seed) & 3;
				end
				if (wait_cycles == 0) begin
					busy = 1'b0;
					if (mem_req.we) begin
						mem[mem_req.adr[`DC_ADDR_W-1:`DC_BYTE_W]] = mem_req.dat;
						mem_wr_cnt++;
						last_wr_adr = mem_req.adr;
						last_wr_dat = mem_req.dat;
					end else begin
						mem_rsp.dat = mem[mem_req.adr[`DC_ADDR_W-1:`DC_BYTE_W]];
						mem_rd_cnt++;
					end
					mem_rsp.ack = 1'b1;
				end else begin
					wait_cycles--;
				end
			end
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * (NUM_STEPS * 40 + 4));
		$display("timeout: the cache stopped answering the processor");
		$display("STATUS: FAIL");
		$fatal(1);
	end

	initial begin : stimulus
		int rd_before;
		int wr_before;
		int cycles;
		int widx;
		cpu_req = '0;
		load_table();
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = fill_word(i);
		end
		@(posedge rst_n);
		@(posedge CLK);
		#1;
		// both bus sides idle after reset
		check_equal("cpu_rsp.ack", 32'(cpu_rsp.ack), 0);
		check_equal("mem_req.cyc", 32'(mem_req.cyc), 0);
		check_equal("mem_req.stb", 32'(mem_req.stb), 0);
		check_equal("mem_req.we", 32'(mem_req.we), 0);
		for (int n = 0; n < NUM_STEPS; n++) begin
			rd_before   = mem_rd_cnt;
			wr_before   = mem_wr_cnt;
			widx        = int'(steps[n].adr[`DC_ADDR_W-1:`DC_BYTE_W]);
			cpu_req.cyc = 1'b1;
			cpu_req.stb = 1'b1;
			cpu_req.we  = steps[n].we;
			cpu_req.adr = steps[n].adr;
			cpu_req.dat = steps[n].dat;
			cycles      = 0;
			do begin
				@(posedge CLK);
				#1;
				cycles++;
			end while (!cpu_rsp.ack);
			// memory cycle already closed when the processor sees ack
			check_equal("mem_req.cyc", 32'(mem_req.cyc), 0);
			if (steps[n].we) begin
				shadow[widx] = steps[n].dat;
				check_equal("mem write count", mem_wr_cnt - wr_before, 1);
				check_equal("mem_req.adr", 32'(last_wr_adr), 32'(steps[n].adr));
				check_equal("mem_req.dat", last_wr_dat, steps[n].dat);
			end else begin
				check_equal("cpu_rsp.dat", cpu_rsp.dat, shadow[widx]);
				check_equal("mem write count", mem_wr_cnt - wr_before, 0);
				// a hit answers two edges after the strobe is taken
				if (steps[n].reads == 3'd0) begin
					check_equal("read hit latency", cycles, 2);
				end
			end
			check_equal("mem read count", mem_rd_cnt - rd_before, 32'(steps[n].reads));
			@(posedge CLK);
			#1;
			cpu_req.cyc = 1'b0;
			cpu_req.stb = 1'b0;
			cpu_req.we  = 1'b0;
			check_equal("cpu_rsp.ack", 32'(cpu_rsp.ack), 0);
			@(posedge CLK);
			#1;
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address width on both bus ports
`define DC_ADDR_W 12

// data word width
`define DC_DATA_W 32

// cache geometry
`define DC_LINES 8
`define DC_WORDS 4

// address fields, from low to high:
// byte in word, word offset, line index, tag
`define DC_BYTE_W 2
`define DC_OFFSET_W 2
`define DC_INDEX_W 3
`define DC_TAG_W 5

`endif

// File: verilog/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  wire         CLK,
	input  wire         rst_n,
	input  wire wb_req_t cpu_req,
	input  wire wb_rsp_t mem_rsp,
	input  wire         hit,
	input  wire word_t  rd_word,
	input  wire offset_t beat,
	input  wire         last_beat,
	output wb_rsp_t     cpu_rsp,
	output wb_req_t     mem_req,
	output logic        tag_wr,
	output logic        tag_valid,
	output logic        line_wr,
	output offset_t     line_wr_off,
	output word_t       line_wr_dat,
	output logic        cnt_start,
	output logic        cnt_step
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// word returned to the processor
	word_t rsp_dat;

	offset_t req_off;
	addr_t   refill_adr;

	assign req_off = adr_offset(cpu_req.adr);

	// refill walks the line from word 0 upward
	assign refill_adr = {adr_tag(cpu_req.adr), adr_index(cpu_req.adr), beat,
		{`DC_BYTE_W{1'b0}}};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// stores are read a cycle before lookup, so rd_word is valid here
	always_ff @(posedge CLK) begin
		if (state == ST_LOOKUP) begin
			rsp_dat <= rd_word;
		end else if (state == ST_REFILL && mem_rsp.ack && beat == req_off) begin
			// take the requested word straight off the bus
			rsp_dat <= mem_rsp.dat;
		end
	end

	always_comb begin
		state_nxt   = state;
		tag_wr      = 1'b0;
		tag_valid   = 1'b0;
		line_wr     = 1'b0;
		line_wr_off = req_off;
		line_wr_dat = cpu_req.dat;
		cnt_start   = 1'b0;
		cnt_step    = 1'b0;
		case (state)
			ST_IDLE: begin
				if (cpu_req.cyc && cpu_req.stb) begin
					state_nxt = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (cpu_req.we) begin
					state_nxt = ST_WRITE;
				end else if (hit) begin
					state_nxt = ST_ACK;
				end else begin
					// invalidate the line until the whole refill is in
					state_nxt = ST_REFILL;
					tag_wr    = 1'b1;
					tag_valid = 1'b0;
					cnt_start = 1'b1;
				end
			end
			ST_REFILL: begin
				if (mem_rsp.ack) begin
					line_wr     = 1'b1;
					line_wr_off = beat;
					line_wr_dat = mem_rsp.dat;
					cnt_step    = 1'b1;
					if (last_beat) begin
						tag_wr    = 1'b1;
						tag_valid = 1'b1;
						state_nxt = ST_ACK;
					end
				end
			end
			ST_WRITE: begin
				// tag store is untouched during a write, hit still holds
				if (mem_rsp.ack) begin
					line_wr   = hit;
					state_nxt = ST_ACK;
				end
			end
			ST_ACK: begin
				state_nxt = ST_IDLE;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// memory side master
	always_comb begin
		mem_req     = '0;
		mem_req.adr = refill_adr;
		mem_req.dat = cpu_req.dat;
		case (state)
			ST_REFILL: begin
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
			end
			ST_WRITE: begin
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
				mem_req.we  = 1'b1;
				mem_req.adr = cpu_req.adr;
			end
			default: begin
			end
		endcase
	end

	assign cpu_rsp.ack = (state == ST_ACK);
	assign cpu_rsp.dat = rsp_dat;

	a_ack_needs_stb: assert property (@(posedge CLK) disable iff (!rst_n)
		cpu_rsp.ack |-> cpu_req.stb)
		else $error("cpu ack without processor strobe");

	a_stb_needs_cyc: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_req.stb |-> mem_req.cyc)
		else $error("memory strobe outside a cycle");

	// request must not move while memory stalls
	a_mem_req_held: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_req.stb && !mem_rsp.ack |=> $stable(mem_req))
		else $error("memory request changed before ack");

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	`include "dcache_cfg.svh"

	// widths with a meaning of their own
	typedef logic [`DC_ADDR_W-1:0]   addr_t;
	typedef logic [`DC_DATA_W-1:0]   word_t;
	typedef logic [`DC_TAG_W-1:0]    tag_t;
	typedef logic [`DC_INDEX_W-1:0]  index_t;
	typedef logic [`DC_OFFSET_W-1:0] offset_t;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL,
		ST_WRITE,
		ST_ACK
	} ctrl_state_t;

	// wishbone classic request, master to slave
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		word_t dat;
	} wb_req_t;

	// wishbone classic response, slave to master
	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	// address field extraction
	function automatic tag_t adr_tag(addr_t adr);
		return adr[`DC_ADDR_W-1 -: `DC_TAG_W];
	endfunction

	function automatic index_t adr_index(addr_t adr);
		return adr[`DC_BYTE_W+`DC_OFFSET_W +: `DC_INDEX_W];
	endfunction

	function automatic offset_t adr_offset(addr_t adr);
		return adr[`DC_BYTE_W +: `DC_OFFSET_W];
	endfunction

endpackage

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
	input  wire          CLK,
	input  wire          rst_n,
	input  wire wb_req_t cpu_req,
	input  wire wb_rsp_t mem_rsp,
	output wb_rsp_t      cpu_rsp,
	output wb_req_t      mem_req
);

	// store results
	logic  hit;
	word_t rd_word;

	// refill beat
	offset_t beat;
	logic    last_beat;
	logic    cnt_start;
	logic    cnt_step;

	// store writes
	logic    tag_wr;
	logic    tag_valid;
	logic    line_wr;
	offset_t line_wr_off;
	word_t   line_wr_dat;

	dcache_ctrl u_ctrl (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.mem_rsp     (mem_rsp),
		.hit         (hit),
		.rd_word     (rd_word),
		.beat        (beat),
		.last_beat   (last_beat),
		.cpu_rsp     (cpu_rsp),
		.mem_req     (mem_req),
		.tag_wr      (tag_wr),
		.tag_valid   (tag_valid),
		.line_wr     (line_wr),
		.line_wr_off (line_wr_off),
		.line_wr_dat (line_wr_dat),
		.cnt_start   (cnt_start),
		.cnt_step    (cnt_step)
	);

	refill_counter u_cnt (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.start     (cnt_start),
		.step      (cnt_step),
		.beat      (beat),
		.last_beat (last_beat)
	);

	// both stores look at the live processor address
	tag_store u_tags (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.lookup_adr (cpu_req.adr),
		.wr         (tag_wr),
		.valid_in   (tag_valid),
		.hit        (hit)
	);

	line_store u_lines (
		.CLK     (CLK),
		.adr     (cpu_req.adr),
		.wr      (line_wr),
		.wr_off  (line_wr_off),
		.wr_dat  (line_wr_dat),
		.rd_word (rd_word)
	);

endmodule

`default_nettype wire

// File: verilog/line_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module line_store import dcache_pkg::*; (
	input  wire          CLK,
	input  wire addr_t   adr,
	input  wire          wr,
	input  wire offset_t wr_off,
	input  wire word_t   wr_dat,
	output word_t        rd_word
);

	// eight lines of four words
	word_t mem [`DC_LINES][`DC_WORDS];

	index_t  idx;
	offset_t rd_off;

	assign idx    = adr_index(adr);
	assign rd_off = adr_offset(adr);

	// write port, word chosen by the controller
	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[idx][wr_off] <= wr_dat;
		end
	end

	// registered read of the addressed word
	always_ff @(posedge CLK) begin
		rd_word <= mem[idx][rd_off];
	end

endmodule

`default_nettype wire

// File: verilog/refill_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module refill_counter import dcache_pkg::*; (
	input  wire     CLK,
	input  wire     rst_n,
	input  wire     start,
	input  wire     step,
	output offset_t beat,
	output logic    last_beat
);

	offset_t beat_q;

	// a refill is running
	logic active;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			beat_q <= '0;
			active <= 1'b0;
		end else if (start) begin
			beat_q <= '0;
			active <= 1'b1;
		end else if (step && active) begin
			// wraps back to zero after the last word
			beat_q <= beat_q + 1'b1;
			if (last_beat) begin
				active <= 1'b0;
			end
		end
	end

	assign beat      = beat_q;
	assign last_beat = (beat_q == offset_t'(`DC_WORDS - 1));

	a_step_in_refill: assert property (@(posedge CLK) disable iff (!rst_n)
		step |-> active)
		else $error("refill step without a started refill");

endmodule

`default_nettype wire

// File: verilog/tag_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module tag_store import dcache_pkg::*; (
	input  wire        CLK,
	input  wire        rst_n,
	input  wire addr_t lookup_adr,
	input  wire        wr,
	input  wire        valid_in,
	output logic       hit
);

	logic [`DC_LINES-1:0] valid;
	tag_t                 tags [`DC_LINES];

	index_t idx;
	tag_t   tag;

	assign idx = adr_index(lookup_adr);
	assign tag = adr_tag(lookup_adr);

	// valid bits
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (wr) begin
			valid[idx] <= valid_in;
		end
	end

	// tags are only meaningful behind a set valid bit
	always_ff @(posedge CLK) begin
		if (wr) begin
			tags[idx] <= tag;
		end
	end

	// compare every cycle, result lands one edge later
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			hit <= 1'b0;
		end else begin
			hit <= valid[idx] && (tags[idx] == tag);
		end
	end

endmodule

`default_nettype wire
